/* common/rs_defines.svh */
// RS syndrome front end sizes
// one field, GF(32), and one code strength, t = 6
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// symbol width in bits
`define RS_M 5

// longest frame, the full code length 2^m - 1
`define RS_N 31

// number of syndromes, 2t
`define RS_NSYN 12

// credits the source holds after reset
`define RS_IN_CREDITS 2

// result credits the DUT holds after reset
`define RS_OUT_CREDITS 4

// syndrome sets the output queue can hold
`define RS_QUEUE_DEPTH 2

`endif

/* common/rs_pkg.sv */
// RS field package
// GF(32) element and syndrome types plus the constant alpha-power multiplier
`default_nettype none

`include "rs_defines.svh"

package rs_pkg;

	// one field element, polynomial basis, bit k is the x^k coefficient
	typedef logic [`RS_M-1:0] gf_elem_t;

	// frame length, wide enough to hold RS_N
	typedef logic [$clog2(`RS_N + 1)-1:0] frame_len_t;

	// index of one syndrome inside a set
	typedef logic [$clog2(`RS_NSYN)-1:0] syn_index_t;

	// all syndromes of one frame, element i holds S_i
	typedef logic [`RS_NSYN-1:0][`RS_M-1:0] syndrome_set_t;

	// primitive polynomial x^5 + x^2 + 1
	localparam logic [`RS_M:0] GF_POLY = 6'b100101;

	// ------------------------------
	// x * alpha^pow
	// ------------------------------
	// built from repeated multiply by alpha, a shift with a conditional reduction
	// when pow is a constant at the call site this folds into a small xor network
	function automatic gf_elem_t gf_mul_alpha_pow(gf_elem_t x, int unsigned pow);
		gf_elem_t r;
		int unsigned p;
		int k;
		r = x;
		// alpha has order 31 so only pow modulo 31 matters
		p = pow % `RS_N;
		for (k = 0; k < `RS_N; k++)
		begin
			if (k < int'(p))
			begin
				// the bit shifted out of x^4 folds back as x^2 + 1
				r = {r[`RS_M-2:0], 1'b0} ^ (r[`RS_M-1] ? GF_POLY[`RS_M-1:0] : '0);
			end
		end
		return r;
	endfunction

endpackage

`default_nettype wire

/* src/rs_symbol_intake.sv */
// RS symbol intake
// takes symbols under input credits, tracks the frame length and tags
// the first and last symbol of each frame
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module rs_symbol_intake (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	input  rs_pkg::gf_elem_t   in_symbol,
	input  rs_pkg::frame_len_t in_frame_len,
	input  logic               queue_full,
	output logic               in_credit,
	output logic               sym_valid,
	output rs_pkg::gf_elem_t   sym_data,
	output logic               sym_first,
	output logic               sym_last
);
	import rs_pkg::*;

	localparam int CR_W = $clog2(`RS_IN_CREDITS + 1);

	// high while a frame is open, i.e. after its first symbol
	logic in_frame;
	// symbols still to come after the last accepted one
	frame_len_t remain;
	// last-symbol credits not yet handed back
	logic [CR_W-1:0] held;
	// credits the source holds, as seen from this side
	logic [CR_W-1:0] src_credits;
	logic is_last;
	logic normal_ret;
	logic release_held;

	// the length field counts only with the first symbol of a frame
	assign is_last = in_frame ? (remain == frame_len_t'(1)) : (in_frame_len == frame_len_t'(1));

	// every symbol but the last gets its credit back right away
	assign normal_ret = in_valid && !is_last;
	// a held credit goes back only when nothing is in flight toward the queue
	// and the queue is not full, one per cycle, after any normal credit
	assign release_held = (held != '0) && !queue_full && !sym_last && !normal_ret;

	// ------------------------------
	// frame tracking
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			in_frame  <= 1'b0;
			remain    <= '0;
			sym_valid <= 1'b0;
			sym_first <= 1'b0;
			sym_last  <= 1'b0;
		end
		else
		begin
			sym_valid <= in_valid;
			sym_first <= in_valid && !in_frame;
			sym_last  <= in_valid && is_last;
			if (in_valid)
			begin
				in_frame <= !is_last;
				remain   <= (in_frame ? remain : in_frame_len) - frame_len_t'(1);
			end
		end
	end

	// the symbol itself is payload and needs no reset
	always_ff @(posedge clk)
	begin
		if (in_valid)
			sym_data <= in_symbol;
	end

	// ------------------------------
	// credit return
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			in_credit   <= 1'b0;
			held        <= '0;
			src_credits <= CR_W'(`RS_IN_CREDITS);
		end
		else
		begin
			in_credit   <= normal_ret || release_held;
			held        <= held + CR_W'(in_valid && is_last) - CR_W'(release_held);
			src_credits <= src_credits - CR_W'(in_valid) + CR_W'(in_credit);
		end
	end

	// the source may only send while it still holds a credit
	a_no_send_without_credit: assert property (
		@(posedge clk) disable iff (!arst_n)
		in_valid |-> (src_credits != '0)
	) else $error("in_valid with no input credit outstanding");

endmodule

`default_nettype wire

/* syndrome/rs_syndrome_bank.sv */
// RS syndrome bank
// twelve Horner accumulators, S_i = r(alpha^(i+1)), first symbol highest degree
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module rs_syndrome_bank (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  sym_valid,
	input  rs_pkg::gf_elem_t      sym_data,
	input  logic                  sym_first,
	input  logic                  sym_last,
	output logic                  set_done,
	output rs_pkg::syndrome_set_t set_data,
	output logic                  set_error
);
	import rs_pkg::*;

	// running syndromes of the frame in progress
	syndrome_set_t acc;
	// high between the first and the last symbol of a frame
	logic frame_open;

	// ------------------------------
	// accumulators
	// ------------------------------
	// each lane is acc = acc * alpha^(i+1) + r_j, restarted on the first symbol
	// the multiplier is a fixed xor network per lane, no general multiplier
	for (genvar g = 0; g < `RS_NSYN; g++)
	begin : g_lane
		gf_elem_t scaled;

		assign scaled = gf_mul_alpha_pow(acc[g], g + 1);

		always_ff @(posedge clk)
		begin
			if (sym_valid)
			begin
				if (sym_first)
					acc[g] <= sym_data;
				else
					acc[g] <= scaled ^ sym_data;
			end
		end
	end

	// ------------------------------
	// frame completion
	// ------------------------------
	// set_done rises the cycle after the last symbol, when acc holds the final values
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			set_done   <= 1'b0;
			frame_open <= 1'b0;
		end
		else
		begin
			set_done <= sym_valid && sym_last;
			if (sym_valid)
				frame_open <= !sym_last;
		end
	end

	assign set_data = acc;

	// any nonzero syndrome means the frame is not a codeword
	assign set_error = |acc;

	// a frame opens only when none is open, and every later symbol needs an open one
	a_frame_order: assert property (
		@(posedge clk) disable iff (!arst_n)
		sym_valid |-> (sym_first != frame_open)
	) else $error("symbol does not fit the open or closed state of the frame");

endmodule

`default_nettype wire

/* syndrome/rs_syndrome_queue.sv */
// RS syndrome queue
// small FIFO of finished syndrome sets and their error flags
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module rs_syndrome_queue (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  set_done,
	input  rs_pkg::syndrome_set_t set_data,
	input  logic                  set_error,
	input  logic                  q_pop,
	output logic                  queue_full,
	output logic                  q_valid,
	output rs_pkg::syndrome_set_t q_data,
	output logic                  q_error
);
	import rs_pkg::*;

	localparam int PTR_W = (`RS_QUEUE_DEPTH > 1) ? $clog2(`RS_QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(`RS_QUEUE_DEPTH + 1);
	// every input credit the source holds can still close one more frame,
	// so the queue stops taking new frames this many entries before the end
	localparam int FULL_AT = `RS_QUEUE_DEPTH - `RS_IN_CREDITS + 1;

	syndrome_set_t mem_data [`RS_QUEUE_DEPTH];
	logic mem_error [`RS_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (set_done)
		begin
			mem_data[wr_ptr]  <= set_data;
			mem_error[wr_ptr] <= set_error;
		end
	end

	// ------------------------------
	// pointers and fill level
	// ------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (set_done)
				wr_ptr <= (wr_ptr == PTR_W'(`RS_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (q_pop)
				rd_ptr <= (rd_ptr == PTR_W'(`RS_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({set_done, q_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the set being written this cycle already counts, it is a committed entry
	assign queue_full = (int'(count) + int'(set_done)) >= FULL_AT;

	// head of queue, visible the cycle after its write
	assign q_valid = count != '0;
	assign q_data  = mem_data[rd_ptr];
	assign q_error = mem_error[rd_ptr];

	// input credit gating upstream must keep the bank from overrunning us
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (!arst_n)
		set_done |-> (count != CNT_W'(`RS_QUEUE_DEPTH))
	) else $error("syndrome set written into a full queue");

	// the transmitter only pops a set it has finished sending
	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!arst_n)
		q_pop |-> (count != '0)
	) else $error("pop from an empty syndrome queue");

endmodule

`default_nettype wire

/* src/rs_result_tx.sv */
// RS result transmitter
// sends one queued syndrome set, index 0 to 11, one word per output credit
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module rs_result_tx (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  q_valid,
	input  rs_pkg::syndrome_set_t q_data,
	input  logic                  q_error,
	input  logic                  res_credit,
	output logic                  q_pop,
	output logic                  res_valid,
	output rs_pkg::syn_index_t    res_index,
	output rs_pkg::gf_elem_t      res_syndrome,
	output logic                  res_error,
	output logic                  res_last
);
	import rs_pkg::*;

	localparam int CR_W = $clog2(`RS_OUT_CREDITS + 1);

	// credits we hold toward the sink
	logic [CR_W-1:0] credits;
	// next syndrome of the head set to go out
	syn_index_t idx;
	logic send;
	logic at_end;

	// a word goes out whenever there is a set and a credit to spend on it
	assign send   = q_valid && (credits != '0);
	assign at_end = idx == syn_index_t'(`RS_NSYN - 1);
	// the set leaves the queue as its last word is taken
	assign q_pop  = send && at_end;

	// ------------------------------
	// control
	// ------------------------------
	// without credits idx stays put, so the set resumes where it stopped
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			credits   <= CR_W'(`RS_OUT_CREDITS);
			idx       <= '0;
			res_valid <= 1'b0;
			res_last  <= 1'b0;
		end
		else
		begin
			credits   <= credits - CR_W'(send) + CR_W'(res_credit);
			res_valid <= send;
			res_last  <= send && at_end;
			if (send)
				idx <= at_end ? '0 : idx + 1'b1;
		end
	end

	// the word itself, only meaningful while res_valid is high
	always_ff @(posedge clk)
	begin
		if (send)
		begin
			res_index    <= idx;
			res_syndrome <= q_data[idx];
			res_error    <= q_error;
		end
	end

	// the sink must never hand back more credits than we spent
	a_credit_bound: assert property (
		@(posedge clk) disable iff (!arst_n)
		credits <= CR_W'(`RS_OUT_CREDITS)
	) else $error("output credit count above its initial value");

endmodule

`default_nettype wire

/* src/rs_syndrome_top.sv */
// RS syndrome front end top level
// intake, syndrome bank, result queue and transmitter in pipeline order
`timescale 1ns/10ps
`default_nettype none

module rs_syndrome_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	input  rs_pkg::gf_elem_t   in_symbol,
	input  rs_pkg::frame_len_t in_frame_len,
	output logic               in_credit,
	output logic               res_valid,
	output rs_pkg::syn_index_t res_index,
	output rs_pkg::gf_elem_t   res_syndrome,
	output logic               res_error,
	output logic               res_last,
	input  logic               res_credit
);
	import rs_pkg::*;

	// intake to bank
	logic sym_valid;
	gf_elem_t sym_data;
	logic sym_first;
	logic sym_last;

	// bank to queue
	logic set_done;
	syndrome_set_t set_data;
	logic set_error;

	// queue to intake and tx
	logic queue_full;
	logic q_valid;
	syndrome_set_t q_data;
	logic q_error;
	logic q_pop;

	rs_symbol_intake u_intake (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_symbol    (in_symbol),
		.in_frame_len (in_frame_len),
		.queue_full   (queue_full),
		.in_credit    (in_credit),
		.sym_valid    (sym_valid),
		.sym_data     (sym_data),
		.sym_first    (sym_first),
		.sym_last     (sym_last)
	);

	rs_syndrome_bank u_bank (
		.clk       (clk),
		.arst_n    (arst_n),
		.sym_valid (sym_valid),
		.sym_data  (sym_data),
		.sym_first (sym_first),
		.sym_last  (sym_last),
		.set_done  (set_done),
		.set_data  (set_data),
		.set_error (set_error)
	);

	rs_syndrome_queue u_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.set_done   (set_done),
		.set_data   (set_data),
		.set_error  (set_error),
		.q_pop      (q_pop),
		.queue_full (queue_full),
		.q_valid    (q_valid),
		.q_data     (q_data),
		.q_error    (q_error)
	);

	rs_result_tx u_tx (
		.clk          (clk),
		.arst_n       (arst_n),
		.q_valid      (q_valid),
		.q_data       (q_data),
		.q_error      (q_error),
		.res_credit   (res_credit),
		.q_pop        (q_pop),
		.res_valid    (res_valid),
		.res_index    (res_index),
		.res_syndrome (res_syndrome),
		.res_error    (res_error),
		.res_last     (res_last)
	);

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
// testbench clock and reset
// 4 ns clock, reset held low for the first 8 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		// release on an edge so the DUT leaves reset cleanly
		arst_n <= 1'b1;
	end

	always #2 clk = ~clk;

endmodule

`default_nettype wire

/* dv/tb_rs_syndrome.sv */
// testbench for the RS syndrome front end
// frames and expected syndromes come from the vector file, output credits
// are returned at LFSR-chosen times and every result word is compared
`timescale 1ns/10ps
`default_nettype none

`include "rs_defines.svh"

module tb_rs_syndrome;
	import rs_pkg::*;

	logic clk;
	logic arst_n;
	logic in_valid;
	gf_elem_t in_symbol;
	frame_len_t in_frame_len;
	logic in_credit;
	logic res_valid;
	syn_index_t res_index;
	gf_elem_t res_syndrome;
	logic res_error;
	logic res_last;
	logic res_credit;

	// raw vector words and the frames parsed out of them
	logic [7:0] vec [0:1023];
	int nframes;
	int total_syms;
	int frame_pos [32];
	int frame_len [32];
	bit frame_flag [32];
	gf_elem_t frame_syn [32][`RS_NSYN];

	// symbols waiting for an input credit, in send order
	gf_elem_t sq_sym [$];
	frame_len_t sq_len [$];
	bit sq_last [$];
	// frames whose results are still due, in arrival order
	int exp_q [$];
	int widx;
	int src_cr;
	int out_cr;
	int owed;
	int credit_seen;
	int frames_in_done;
	int frames_out;
	int error_count;
	int limit_cycles;
	bit hold_out;
	logic [31:0] lfsr;

	tb_clock_gen u_clk (
		.clk    (clk),
		.arst_n (arst_n)
	);

	rs_syndrome_top DUT (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_symbol    (in_symbol),
		.in_frame_len (in_frame_len),
		.in_credit    (in_credit),
		.res_valid    (res_valid),
		.res_index    (res_index),
		.res_syndrome (res_syndrome),
		.res_error    (res_error),
		.res_last     (res_last),
		.res_credit   (res_credit)
	);

	// ------------------------------
	// helpers
	// ------------------------------
	// 32-bit Galois LFSR, right shifting, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic abort_run(string msg);
		error_count++;
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_syndrome(gf_elem_t got, gf_elem_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED res_syndrome got %h expected %h", got, exp));
	endtask

	task automatic check_index(syn_index_t got, syn_index_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED res_index got %h expected %h", got, exp));
	endtask

	task automatic check_flag(string name, bit got, bit exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	endtask

	// queue every symbol of frame f and note that its results are due
	task automatic queue_frame(int f);
		int k;
		for (k = 0; k < frame_len[f]; k++)
		begin
			sq_sym.push_back(gf_elem_t'(vec[frame_pos[f] + k]));
			sq_len.push_back(frame_len_t'(frame_len[f]));
			sq_last.push_back(k == frame_len[f] - 1);
		end
		exp_q.push_back(f);
	endtask

	// compare one result word with the head frame
	task automatic check_word();
		int f;
		if (exp_q.size() == 0)
			abort_run("a result word arrived while no frame was expected");
		if (out_cr == 0)
			abort_run("a result word was sent without an output credit");
		out_cr--;
		owed++;
		f = exp_q[0];
		check_index(res_index, syn_index_t'(widx));
		check_syndrome(res_syndrome, frame_syn[f][widx]);
		check_flag("res_error", res_error, frame_flag[f]);
		check_flag("res_last", res_last, widx == `RS_NSYN - 1);
		widx++;
		if (widx == `RS_NSYN)
		begin
			widx = 0;
			void'(exp_q.pop_front());
			frames_out++;
		end
	endtask

	// ------------------------------
	// source side
	// ------------------------------
	// sends one symbol per cycle while a credit is held
	always @(posedge clk)
	begin
		if (arst_n)
		begin
			src_cr = src_cr + int'(in_credit);
			if (src_cr > 0 && sq_sym.size() > 0)
			begin
				in_valid <= 1'b1;
				in_symbol <= sq_sym.pop_front();
				in_frame_len <= sq_len.pop_front();
				if (sq_last.pop_front())
					frames_in_done++;
				src_cr--;
			end
			else
				in_valid <= 1'b0;
		end
	end

	// ------------------------------
	// sink side
	// ------------------------------
	// a credit pulse counts one edge late, matching when the DUT can spend it
	always @(posedge clk)
	begin
		if (arst_n)
		begin
			if (res_valid)
				check_word();
			out_cr = out_cr + credit_seen;
			credit_seen = int'(res_credit);
			if (owed > 0 && !hold_out)
			begin
				lfsr = lfsr_step(lfsr);
				if (lfsr[0])
				begin
					res_credit <= 1'b1;
					owed--;
				end
				else
					res_credit <= 1'b0;
			end
			else
				res_credit <= 1'b0;
		end
	end

	// ------------------------------
	// watchdog
	// ------------------------------
	initial
	begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, the results did not all arrive in time");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		int p;
		int i;
		int stable;
		in_valid = 1'b0;
		in_symbol = '0;
		in_frame_len = '0;
		res_credit = 1'b0;
		src_cr = `RS_IN_CREDITS;
		out_cr = `RS_OUT_CREDITS;
		owed = 0;
		credit_seen = 0;
		widx = 0;
		frames_in_done = 0;
		frames_out = 0;
		error_count = 0;
		hold_out = 1'b0;
		lfsr = 32'd81642;
		limit_cycles = 0;
		for (i = 0; i < 1024; i++)
			vec[i] = 8'h00;
		$readmemh("dv/rs_frame_vectors.txt", vec);

		// each record is length, flag, twelve syndromes, then the symbols
		p = 0;
		nframes = 0;
		total_syms = 0;
		while (vec[p] != 8'h00 && nframes < 32)
		begin
			frame_len[nframes] = int'(vec[p]);
			frame_flag[nframes] = vec[p + 1][0];
			for (i = 0; i < `RS_NSYN; i++)
				frame_syn[nframes][i] = gf_elem_t'(vec[p + 2 + i]);
			frame_pos[nframes] = p + 2 + `RS_NSYN;
			p = frame_pos[nframes] + frame_len[nframes];
			total_syms += frame_len[nframes];
			nframes++;
		end
		if (nframes == 0)
			abort_run("the vector file holds no frames");
		// both passes send every frame, plus a margin per frame and the hold window
		limit_cycles = 2 * (total_syms + 100 * nframes) + 500;

		wait (arst_n === 1'b1);
		// nothing may move before the first symbol is offered
		repeat (4)
		begin
			@(posedge clk);
			check_flag("in_credit", in_credit, 1'b0);
			check_flag("res_valid", res_valid, 1'b0);
		end

		// first pass, output credits come back at random times
		for (i = 0; i < nframes; i++)
			queue_frame(i);
		while (exp_q.size() != 0 || owed != 0)
			@(posedge clk);

		// second pass at full input rate, sink withholds all credits
		hold_out = 1'b1;
		for (i = 0; i < nframes; i++)
			queue_frame(i);
		stable = 0;
		while (stable < 30)
		begin
			@(posedge clk);
			// the source counts as stalled only while it sends nothing and symbols wait
			if (!in_valid && src_cr == 0 && sq_sym.size() > 0)
				stable++;
			else
				stable = 0;
		end
		if (frames_in_done - frames_out != `RS_QUEUE_DEPTH)
			abort_run($sformatf("input stalled with %0d sets waiting instead of two",
				frames_in_done - frames_out));
		hold_out = 1'b0;
		while (exp_q.size() != 0 || owed != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);

		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/rs_frame_vectors.txt */
// per frame: length, error flag, S0 to S11, then the symbols first to last
// a length of 00 ends the list, all values in hex
1F 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1F 00
00 00 00 00 00 00 00 00 00 00 00 00
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
1F 00
00 00 00 00 00 00 00 00 00 00 00 00
07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07 07
02 01
03 05 09 11 04 0B 15 0C 1B 10 06 0F
01 01
05 01
04 10 0A 0D 11 0E 1D 1B 03 0C 15 1E
00 00 01 00 00
1F 01
12 09 16 0B 17 19 1E 0F 15 18 0C 06
01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
1F 01
05 05 05 05 05 05 05 05 05 05 05 05
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 04
03 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00 00
07 01
10 05 0A 14 0D 1A 11 07 0E 1C 1D 1F
00 00 00 00 00 08 00
10 01
11 0C 12 1A 06 09 0D 03 16 14 13 0B
00 00 00 00 00 01 00 00 00 00 00 00 00 00 00 00
02 00
00 00 00 00 00 00 00 00 00 00 00 00
00 00
00

/* build.f */
+incdir+common
common/rs_pkg.sv
src/rs_symbol_intake.sv
syndrome/rs_syndrome_bank.sv
syndrome/rs_syndrome_queue.sv
src/rs_result_tx.sv
src/rs_syndrome_top.sv
dv/tb_clock_gen.sv
dv/tb_rs_syndrome.sv

/* run_sim.sh */
#!/bin/sh
# build and run the RS syndrome testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_rs_syndrome \
	-Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_rs_syndrome > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
